//--- Bender.yml
package:
  name: ucode_cpu

sources:
  - include_dirs:
      - include
    files:
      - src/ucode_isa_pkg.sv
      - src/ucode_core_pkg.sv
      - src/ucode_mem.sv
      - src/ucode_stack.sv
      - src/ucode_alu.sv
      - src/ucode_sequencer.sv
      - src/ucode_cpu.sv
  - target: simulation
    files:
      - sim/ucode_cpu_assertions.sv
      - sim/ucode_cpu_tb.sv

//--- build.f
+incdir+include
src/ucode_isa_pkg.sv
src/ucode_core_pkg.sv
src/ucode_mem.sv
src/ucode_stack.sv
src/ucode_alu.sv
src/ucode_sequencer.sv
src/ucode_cpu.sv
sim/ucode_cpu_assertions.sv
sim/ucode_cpu_tb.sv

//--- include/ucode_macros.svh
/*
 * Widths and sizes for the microcode CPU.
 * STACK_PTR_W must equal clog2(STACK_DEPTH) and MEM_WORDS must equal 2**ADDR_W.
 */
`ifndef UCODE_MACROS_SVH
`define UCODE_MACROS_SVH

`define UCODE_CELL_W      16    // bits per cell and per instruction word
`define UCODE_ADDR_W      10    // program address bits
`define UCODE_MEM_WORDS   1024  // program memory depth
`define UCODE_STACK_DEPTH 16    // cells per stack, data and return alike
`define UCODE_STACK_PTR_W 4     // stack pointer bits, wraps at depth

`endif

//--- sim/ucode_cpu_assertions.sv
`timescale 1ns/100ps
/*
 * Protocol checks on the CPU top, attached to every ucode_cpu by bind.
 * All properties are off while reset is low.
 */
module ucode_cpu_assertions (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_emit_valid,
    input logic i_running,
    input logic i_status
);

    int unsigned err_count = 0;     // failed assertion attempts so far

    // emit is a single-cycle strobe
    a_emit_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_emit_valid |=> !i_emit_valid)
        else begin
            $error("emit strobe held for two cycles");
            err_count++;
        end

    a_emit_running: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_emit_valid |-> i_running)
        else begin
            $error("emit strobe while the core is stopped");
            err_count++;
        end

    // illegal opcode is sticky until reset
    a_status_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_status |=> !i_status)
        else begin
            $error("status rose again without a reset");
            err_count++;
        end

endmodule

bind ucode_cpu ucode_cpu_assertions u_assert (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_emit_valid (o_emit_valid),
    .i_running    (o_running),
    .i_status     (o_status)
);

//--- sim/ucode_cpu_tb.sv
`timescale 1ns/100ps
/*
 * Testbench for the microcode CPU. Each test resets the core, loads a short
 * program from address 0, runs it until o_running falls and compares the
 * emitted cells and o_status. Memory is not cleared between tests.
 */
module ucode_cpu_tb;
    import ucode_isa_pkg::*;
    import ucode_core_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int WATCHDOG_NS = 6 * 40 * 4 * CLK_PERIOD + 20000;  // tests x instr x phases

    logic    clk   = 1'b0;
    logic    rst_n = 1'b0;
    logic    run   = 1'b0;
    mem_wr_t load  = '0;
    logic    emit_valid;
    cell_t   emit_data;
    logic    running;
    logic    status;

    integer  seed = 32'h3bba_36eb;
    string   test_name;
    cell_t   prog [$];                      // program words, address 0 upward
    cell_t   exp_q [$];                     // expected emits in order
    cell_t   emit_q [$];                    // emits seen on the port
    logic    exp_status;
    int      checks_req  = 0;               // bumped by the stimulus side
    int      checks_done = 0;               // bumped by the checker
    int      pass_count  = 0;
    int      fail_count  = 0;

    ucode_cpu dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_run        (run),
        .i_load       (load),
        .o_emit_valid (emit_valid),
        .o_emit_data  (emit_data),
        .o_running    (running),
        .o_status     (status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (emit_valid) begin
            emit_q.push_back(emit_data);    // no back-pressure, take every strobe
        end
    end

    // expected result, unary ops act on the top cell y
    function automatic cell_t ref_alu(input opcode_e op, input cell_t x, input cell_t y);
        case (op)
            UC_ADD:  return x + y;
            UC_SUB:  return x - y;
            UC_AND:  return x & y;
            UC_OR:   return x | y;
            UC_XOR:  return x ^ y;
            UC_INC:  return y + 16'd1;
            UC_DEC:  return y - 16'd1;
            UC_NOT:  return ~y;
            UC_NEG:  return 16'd0 - y;
            UC_ROL:  return (y << 1) | (y >> ($bits(cell_t) - 1));
            default: return y;
        endcase
    endfunction

    always begin : compare_results
        int errs;
        wait (checks_req != checks_done);
        errs = 0;
        if (emit_q.size() != exp_q.size()) begin
            $display("FAIL %s: emit count expected %0d actual %0d",
                     test_name, exp_q.size(), emit_q.size());
            errs++;
        end
        for (int i = 0; i < exp_q.size() && i < emit_q.size(); i++) begin
            if (emit_q[i] !== exp_q[i]) begin
                $display("FAIL %s: emit[%0d] expected %h actual %h",
                         test_name, i, exp_q[i], emit_q[i]);
                errs++;
            end
        end
        if (status !== exp_status) begin
            $display("FAIL %s: status expected %b actual %b", test_name, exp_status, status);
            errs++;
        end
        if (running !== 1'b0) begin
            $display("FAIL %s: core is still running after it should have stopped", test_name);
            errs++;
        end
        if (errs == 0) begin
            $display("PASS %s", test_name);
            pass_count++;
        end else begin
            fail_count++;
        end
        checks_done++;
    end

    task automatic reset_dut();
        rst_n = 1'b0;
        run   = 1'b0;
        load  = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(posedge clk);
            #2;
            load = '{we: 1'b1, addr: addr_t'(i), data: prog[i]};
        end
        @(posedge clk);
        #2;
        load = '0;
    endtask

    task automatic run_test(input string name, input logic want_status);
        test_name  = name;
        exp_status = want_status;
        reset_dut();
        load_program();
        emit_q.delete();
        run = 1'b1;
        @(posedge clk);
        while (running) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);          // a stray emit after the stop lands here
        #2;
        checks_req++;
        wait (checks_done == checks_req);
        run = 1'b0;
        prog.delete();
        exp_q.delete();
    endtask

    initial begin
        opcode_e alu_ops [10];
        cell_t   a;
        cell_t   b;
        alu_ops = '{UC_ADD, UC_SUB, UC_AND, UC_OR, UC_XOR,
                    UC_INC, UC_DEC, UC_NOT, UC_NEG, UC_ROL};
        foreach (alu_ops[k]) begin
            a    = cell_t'($random(seed));
            b    = cell_t'($random(seed));
            prog = {UC_LIT, a, UC_LIT, b, alu_ops[k], UC_EMIT, UC_EXTN};
            exp_q.push_back(ref_alu(alu_ops[k], a, b));
            run_test({"alu ", alu_ops[k].name()}, 1'b1);
        end

        a     = cell_t'($random(seed));
        b     = cell_t'($random(seed));
        prog  = {UC_LIT, a, UC_LIT, b, UC_OVER, UC_SWAP, UC_DUP, UC_DROP,
                 UC_EMIT, UC_EMIT, UC_EMIT, UC_EXTN};
        exp_q = {b, a, a};                  // ( a b ) over swap dup drop gives ( a a b )
        run_test("stack shuffles", 1'b1);

        a     = cell_t'($random(seed));
        prog  = {UC_LIT, a, UC_LIT, 16'h0200, UC_STORE,
                 UC_LIT, 16'h0200, UC_FETCH, UC_EMIT, UC_EXTN};
        exp_q = {a};                        // fetch leaves ( addr cell )
        run_test("memory", 1'b1);

        a     = cell_t'($random(seed));
        prog  = {UC_LIT, a, 16'h8020,       // call subroutine at 0x20
                 UC_LIT, 16'hAAAA, UC_LIT, 16'h0000, UC_SKZ, UC_EMIT,
                 UC_LIT, 16'hBBBB, UC_LIT, 16'h0001, UC_SKZ, UC_EMIT, UC_EMIT, UC_EXTN};
        while (prog.size() < 'h20) begin
            prog.push_back(UC_NOP);
        end
        prog.push_back(UC_PUSH_R);
        prog.push_back(UC_R_POP);
        prog.push_back(UC_EMIT);
        prog.push_back(UC_EXIT);
        exp_q = {a, 16'hBBBB, 16'hAAAA};    // first emit skipped, second one kept
        run_test("control flow", 1'b1);

        a     = cell_t'($random(seed));
        b     = cell_t'($random(seed));
        prog  = {UC_LIT, a, UC_EMIT, UC_LIT, b, UC_EXTN, UC_LIT, b, UC_EMIT, UC_EMIT};
        exp_q = {a};
        run_test("halt", 1'b1);

        a     = cell_t'($random(seed));
        b     = cell_t'($random(seed));
        prog  = {UC_LIT, a, UC_EMIT, 16'h0030, UC_LIT, b, UC_EMIT, UC_EXTN};
        exp_q = {a};                        // 0x0030 is unassigned
        run_test("illegal opcode", 1'b0);

        $display("tests: %0d passed, %0d failed, %0d assertion failures",
                 pass_count, fail_count, dut.u_assert.err_count);
        if (fail_count == 0 && dut.u_assert.err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the core did not stop running within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- src/ucode_alu.sv
`timescale 1ns/100ps
/*
 * Registered ALU, result one clock after the request.
 * ALU_NOP leaves the previous result in place.
 */
module ucode_alu (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  ucode_core_pkg::alu_req_t i_req,
    output ucode_isa_pkg::cell_t     o_data
);
    import ucode_isa_pkg::*;
    import ucode_core_pkg::*;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data <= c_false;
        end else begin
            case (i_req.op)
                ALU_ADD: o_data <= i_req.arg0 + i_req.arg1;
                ALU_SUB: o_data <= i_req.arg0 - i_req.arg1;     // arg0 is the minuend
                ALU_AND: o_data <= i_req.arg0 & i_req.arg1;
                ALU_OR:  o_data <= i_req.arg0 | i_req.arg1;
                ALU_XOR: o_data <= i_req.arg0 ^ i_req.arg1;
                ALU_ROL: o_data <= {i_req.arg0[$bits(cell_t)-2:0], i_req.arg0[$bits(cell_t)-1]};
                default: o_data <= o_data;                      // nop holds
            endcase
        end
    end

endmodule

//--- src/ucode_core_pkg.sv
/*
 * Datapath control types shared by the sequencer and the blocks it drives.
 * Every control struct is a one-cycle request, applied at the next clock edge.
 */
package ucode_core_pkg;

    typedef enum logic [1:0] {
        PH_FETCH,       // wait for run, bump pc
        PH_DECODE,      // instruction word is on the read port
        PH_EXECUTE,     // alu result valid
        PH_WRITEBACK    // memory data valid, next address out
    } phase_e;

    typedef enum logic [2:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_ROL
    } alu_op_e;

    typedef struct packed {
        logic                 push;     // push alone grows, with pop replaces top
        logic                 pop;
        logic                 swap;     // exchange top two cells
        ucode_isa_pkg::cell_t value;
    } stack_ctl_t;

    typedef struct packed {
        logic                 we;
        ucode_isa_pkg::addr_t addr;
        ucode_isa_pkg::cell_t data;
    } mem_wr_t;

    typedef struct packed {
        alu_op_e              op;
        ucode_isa_pkg::cell_t arg0;     // left operand
        ucode_isa_pkg::cell_t arg1;     // right operand
    } alu_req_t;

endpackage

//--- src/ucode_cpu.sv
`timescale 1ns/100ps
/*
 * Microcode stack CPU top. Load the program through i_load only while i_run is
 * low. o_status is meaningful once o_running falls: 1 halted, 0 illegal opcode.
 */
module ucode_cpu (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_run,
    input  ucode_core_pkg::mem_wr_t i_load,
    output logic                    o_emit_valid,
    output ucode_isa_pkg::cell_t    o_emit_data,
    output logic                    o_running,
    output logic                    o_status
);
    import ucode_isa_pkg::*;
    import ucode_core_pkg::*;

    addr_t      raddr;
    cell_t      rdata;
    mem_wr_t    store;
    stack_ctl_t d_ctl;
    stack_ctl_t r_ctl;
    cell_t      d0;
    cell_t      d1;
    cell_t      r0;
    alu_req_t   alu_req;
    cell_t      alu_data;

    ucode_mem u_mem (
        .i_clk   (i_clk),
        .i_load  (i_load),
        .i_store (store),
        .i_raddr (raddr),
        .o_rdata (rdata)
    );

    ucode_stack d_stack (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctl   (d_ctl),
        .o_s0    (d0),
        .o_s1    (d1)
    );

    ucode_stack r_stack (                       // return stack, only its top is read
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctl   (r_ctl),
        .o_s0    (r0),
        .o_s1    ()
    );

    ucode_alu u_alu (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (alu_req),
        .o_data  (alu_data)
    );

    ucode_sequencer u_seq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_run        (i_run),
        .i_rdata      (rdata),
        .i_d0         (d0),
        .i_d1         (d1),
        .i_r0         (r0),
        .i_alu_data   (alu_data),
        .o_raddr      (raddr),
        .o_store      (store),
        .o_d_ctl      (d_ctl),
        .o_r_ctl      (r_ctl),
        .o_alu_req    (alu_req),
        .o_emit_valid (o_emit_valid),
        .o_emit_data  (o_emit_data),
        .o_running    (o_running),
        .o_status     (o_status)
    );

endmodule

//--- src/ucode_isa_pkg.sv
/*
 * Instruction-set types. Any word with the top bit set is a CALL to its low
 * address bits, so CALL has no named value in the opcode enum.
 */
`include "ucode_macros.svh"

package ucode_isa_pkg;

    typedef logic [`UCODE_CELL_W-1:0] cell_t;   // data or instruction word
    typedef logic [`UCODE_ADDR_W-1:0] addr_t;   // program address

    typedef enum cell_t {
        UC_NOP    = 16'h0000,   // ( -- )
        UC_ADD    = 16'h0001,   // ( a b -- a+b )
        UC_AND    = 16'h0002,   // ( a b -- a&b )
        UC_XOR    = 16'h0003,   // ( a b -- a^b )
        UC_ROL    = 16'h0004,   // ( a -- a rotated left by one )
        UC_INC    = 16'h0005,   // ( a -- a+1 )
        UC_FETCH  = 16'h0006,   // ( addr -- addr cell ) cell is pushed
        UC_STORE  = 16'h0007,   // ( cell addr -- )
        UC_DUP    = 16'h0008,   // ( a -- a a )
        UC_DROP   = 16'h0009,   // ( a -- )
        UC_SWAP   = 16'h000A,   // ( a b -- b a )
        UC_SKZ    = 16'h000B,   // ( cond -- ) skip next word on zero
        UC_PUSH_R = 16'h000C,   // >R ( a -- ) R:( -- a )
        UC_R_POP  = 16'h000D,   // R> ( -- a ) R:( a -- )
        UC_EXTN   = 16'h000E,   // ( x -- ) halts the core
        UC_EXIT   = 16'h000F,   // R:( addr -- ) addr->pc
        UC_LIT    = 16'h0020,   // ( -- item ) item is the next word
        UC_SUB    = 16'h0021,   // ( a b -- a-b )
        UC_OR     = 16'h0022,   // ( a b -- a|b )
        UC_NOT    = 16'h0023,   // ( a -- ~a )
        UC_NEG    = 16'h0024,   // ( a -- -a )
        UC_DEC    = 16'h0025,   // ( a -- a-1 )
        UC_OVER   = 16'h002A,   // ( a b -- a b a )
        UC_EMIT   = 16'h003F    // ( a -- ) a goes out on the emit port
    } opcode_e;

    localparam cell_t c_true  = '1;     // boolean true, all ones
    localparam cell_t c_false = '0;     // boolean false

endpackage

//--- src/ucode_mem.sv
`timescale 1ns/100ps
/*
 * Program memory, one read port and two write ports. Load beats store, and any
 * write suppresses the read so o_rdata holds. Contents are undefined until loaded.
 */
`include "ucode_macros.svh"

module ucode_mem (
    input  logic                    i_clk,
    input  ucode_core_pkg::mem_wr_t i_load,     // external program load
    input  ucode_core_pkg::mem_wr_t i_store,    // STORE from the sequencer
    input  ucode_isa_pkg::addr_t    i_raddr,
    output ucode_isa_pkg::cell_t    o_rdata     // one cycle after i_raddr
);
    import ucode_isa_pkg::*;

    cell_t mem [0:`UCODE_MEM_WORDS-1];          // inferred block ram

    always_ff @(posedge i_clk) begin
        if (i_load.we) begin
            mem[i_load.addr] <= i_load.data;    // loader wins
        end else if (i_store.we) begin
            mem[i_store.addr] <= i_store.data;
        end else begin
            o_rdata <= mem[i_raddr];            // read only when idle
        end
    end

endmodule

//--- src/ucode_sequencer.sv
`timescale 1ns/100ps
/*
 * Four-phase fetch/decode/execute/writeback engine, 4 cycles per instruction.
 * Halt (EXTN) and an illegal opcode are sticky until reset. With i_run low the
 * engine parks in FETCH; i_run must not drop in the middle of an instruction.
 */
module ucode_sequencer (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_run,
    input  ucode_isa_pkg::cell_t       i_rdata,       // program memory read data
    input  ucode_isa_pkg::cell_t       i_d0,          // data stack top
    input  ucode_isa_pkg::cell_t       i_d1,          // data stack next
    input  ucode_isa_pkg::cell_t       i_r0,          // return stack top
    input  ucode_isa_pkg::cell_t       i_alu_data,
    output ucode_isa_pkg::addr_t       o_raddr,
    output ucode_core_pkg::mem_wr_t    o_store,
    output ucode_core_pkg::stack_ctl_t o_d_ctl,
    output ucode_core_pkg::stack_ctl_t o_r_ctl,
    output ucode_core_pkg::alu_req_t   o_alu_req,
    output logic                       o_emit_valid,  // one-cycle strobe, no back-pressure
    output ucode_isa_pkg::cell_t       o_emit_data,
    output logic                       o_running,
    output logic                       o_status       // 0 after an illegal opcode
);
    import ucode_isa_pkg::*;
    import ucode_core_pkg::*;

    phase_e  phase;
    addr_t   pc;
    opcode_e opcode;        // CALL words sit outside the named values
    logic    halted;

    assign o_running = i_run & o_status & ~halted;

    // request goes out during DECODE so the registered result is there in EXECUTE
    always_comb begin
        o_alu_req.op   = ALU_NOP;
        o_alu_req.arg0 = i_d1;                      // binary ops take ( d1 d0 )
        o_alu_req.arg1 = i_d0;
        if (phase == PH_DECODE) begin
            case (i_rdata)
                UC_ADD: o_alu_req.op = ALU_ADD;
                UC_SUB: o_alu_req.op = ALU_SUB;
                UC_AND: o_alu_req.op = ALU_AND;
                UC_OR:  o_alu_req.op = ALU_OR;
                UC_XOR: o_alu_req.op = ALU_XOR;
                UC_ROL: begin
                    o_alu_req.op   = ALU_ROL;
                    o_alu_req.arg0 = i_d0;
                end
                UC_INC, UC_DEC: begin
                    o_alu_req.op   = (i_rdata == UC_INC) ? ALU_ADD : ALU_SUB;
                    o_alu_req.arg0 = i_d0;
                    o_alu_req.arg1 = cell_t'(1);
                end
                UC_NOT: begin
                    o_alu_req.op   = ALU_XOR;       // invert by xor with all ones
                    o_alu_req.arg0 = i_d0;
                    o_alu_req.arg1 = c_true;
                end
                UC_NEG: begin
                    o_alu_req.op   = ALU_SUB;       // 0 - a
                    o_alu_req.arg0 = c_false;
                    o_alu_req.arg1 = i_d0;
                end
                default: o_alu_req.op = ALU_NOP;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase        <= PH_FETCH;
            pc           <= '0;
            opcode       <= UC_NOP;
            halted       <= 1'b0;
            o_status     <= 1'b1;
            o_raddr      <= '0;
            o_store      <= '0;
            o_d_ctl      <= '0;
            o_r_ctl      <= '0;                     // swap field stays 0 for good
            o_emit_valid <= 1'b0;
            o_emit_data  <= '0;
        end else begin
            o_store.we   <= 1'b0;                   // strobes last one cycle
            o_d_ctl.push <= 1'b0;
            o_d_ctl.pop  <= 1'b0;
            o_d_ctl.swap <= 1'b0;
            o_r_ctl.push <= 1'b0;
            o_r_ctl.pop  <= 1'b0;
            o_emit_valid <= 1'b0;
            case (phase)
                PH_FETCH: begin
                    if (o_running) begin            // instruction word is being read
                        phase <= PH_DECODE;
                        pc    <= pc + 1'b1;
                    end
                end
                PH_DECODE: begin
                    phase  <= PH_EXECUTE;
                    opcode <= opcode_e'(i_rdata);
                    case (i_rdata)
                        UC_ADD, UC_SUB, UC_AND, UC_OR, UC_XOR: begin
                            o_d_ctl.pop <= 1'b1;    // drop right operand, top replaced later
                        end
                        UC_FETCH: o_raddr <= addr_t'(i_d0);
                        UC_STORE: begin             // ( cell addr -- ), first of two pops
                            o_store.we   <= 1'b1;
                            o_store.addr <= addr_t'(i_d0);
                            o_store.data <= i_d1;
                            o_d_ctl.pop  <= 1'b1;
                        end
                        UC_LIT: o_raddr <= pc;      // literal follows the opcode
                        default: o_raddr <= o_raddr;
                    endcase
                end
                PH_EXECUTE: begin
                    phase <= PH_WRITEBACK;
                    case (opcode)
                        UC_NOP, UC_FETCH: ;         // fetch waits on memory
                        UC_ADD, UC_SUB, UC_AND, UC_OR, UC_XOR, UC_ROL,
                        UC_INC, UC_DEC, UC_NOT, UC_NEG: begin
                            o_d_ctl.value <= i_alu_data;
                            o_d_ctl.pop   <= 1'b1;
                            o_d_ctl.push  <= 1'b1;
                        end
                        UC_STORE, UC_DROP: o_d_ctl.pop <= 1'b1;
                        UC_DUP, UC_OVER: begin
                            o_d_ctl.value <= (opcode == UC_DUP) ? i_d0 : i_d1;
                            o_d_ctl.push  <= 1'b1;
                        end
                        UC_SWAP: o_d_ctl.swap <= 1'b1;
                        UC_SKZ: begin
                            if (i_d0 == c_false) begin
                                pc <= pc + 1'b1;    // skip one word
                            end
                            o_d_ctl.pop <= 1'b1;
                        end
                        UC_PUSH_R: begin
                            o_r_ctl.value <= i_d0;
                            o_r_ctl.push  <= 1'b1;
                            o_d_ctl.pop   <= 1'b1;
                        end
                        UC_R_POP: begin
                            o_d_ctl.value <= i_r0;
                            o_d_ctl.push  <= 1'b1;
                            o_r_ctl.pop   <= 1'b1;
                        end
                        UC_EXTN: begin
                            o_d_ctl.pop <= 1'b1;
                            halted      <= 1'b1;
                        end
                        UC_EXIT: begin
                            pc          <= addr_t'(i_r0);
                            o_r_ctl.pop <= 1'b1;
                        end
                        UC_LIT: pc <= pc + 1'b1;    // step over the literal
                        UC_EMIT: begin
                            o_emit_valid <= 1'b1;
                            o_emit_data  <= i_d0;
                            o_d_ctl.pop  <= 1'b1;
                        end
                        default: begin
                            if (opcode[$bits(cell_t)-1]) begin      // call, return to pc
                                o_r_ctl.value <= cell_t'(pc);
                                o_r_ctl.push  <= 1'b1;
                                pc            <= addr_t'(opcode);
                            end else begin
                                o_status <= 1'b0;   // illegal opcode
                            end
                        end
                    endcase
                end
                PH_WRITEBACK: begin
                    phase <= PH_FETCH;
                    if (opcode == UC_FETCH || opcode == UC_LIT) begin
                        o_d_ctl.value <= i_rdata;
                        o_d_ctl.push  <= 1'b1;
                    end
                    o_raddr <= pc;                  // next instruction word
                end
            endcase
        end
    end

endmodule

//--- src/ucode_stack.sv
`timescale 1ns/100ps
/*
 * Circular LIFO, top two cells visible combinationally.
 * Overflow and underflow wrap the pointer without any flag.
 */
`include "ucode_macros.svh"

module ucode_stack (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  ucode_core_pkg::stack_ctl_t i_ctl,
    output ucode_isa_pkg::cell_t       o_s0,    // top of stack
    output ucode_isa_pkg::cell_t       o_s1     // next on stack
);
    import ucode_isa_pkg::*;

    cell_t                         cells [0:`UCODE_STACK_DEPTH-1];
    logic [`UCODE_STACK_PTR_W-1:0] sp;          // index of top cell
    logic [`UCODE_STACK_PTR_W-1:0] sp_dn;       // cell below top, wraps
    logic [`UCODE_STACK_PTR_W-1:0] sp_up;       // slot for a push, wraps

    assign sp_dn = sp - 1'b1;
    assign sp_up = sp + 1'b1;
    assign o_s0  = cells[sp];
    assign o_s1  = cells[sp_dn];

    // pointer moves only on a lone push or a lone pop
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sp <= '0;
        end else if (i_ctl.push && !i_ctl.pop) begin
            sp <= sp_up;
        end else if (i_ctl.pop && !i_ctl.push) begin
            sp <= sp_dn;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ctl.push) begin
            if (i_ctl.pop) begin
                cells[sp] <= i_ctl.value;       // replace top
            end else begin
                cells[sp_up] <= i_ctl.value;
            end
        end else if (i_ctl.swap) begin
            cells[sp]    <= cells[sp_dn];
            cells[sp_dn] <= cells[sp];
        end
    end

endmodule
